/* axi_xbar.f */
+incdir+src
src/axi_xbar_pkg.sv
src/axi_addr_decoder.sv
src/axi_slave_arbiter.sv
src/axi_read_crossbar.sv
src/axi_xbar.sv
sim/axi_slave_model.sv
sim/axi_xbar_tb.sv

/* sim/axi_slave_model.sv */
`timescale 1ns/1ps
`include "axi_xbar_macros.svh"

module axi_slave_model #(
    parameter int unsigned SLAVE_IDX = 0
) (
    input  logic                    ACLK,
    input  logic                    ARESET,
    input  axi_xbar_pkg::ar_req_s_t ar_s,
    input  logic                    arvalid_s,
    output logic                    arready_s,
    output axi_xbar_pkg::r_resp_s_t r_s,
    output logic                    rvalid_s,
    input  logic                    rready_s
);

    // Slave index on top, beat address below
    function automatic logic [`AXI_DATA_BITS-1:0] beat_data(
        input logic [`AXI_ADDR_BITS-1:0] addr,
        input int unsigned               beat
    );
        logic [27:0] offset;
        offset = addr[27:0] + 28'(beat * 4);
        return {4'(SLAVE_IDX), offset};
    endfunction

    initial begin
        axi_xbar_pkg::ar_req_s_t req;
        int unsigned             delay;

        arready_s = 1'b0;
        rvalid_s  = 1'b0;
        r_s       = '{id: '0, data: '0, resp: `AXI_RESP_OKAY, last: 1'b0};

        forever begin
            @(posedge ACLK);
            if (!ARESET && arvalid_s === 1'b1) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge ACLK);
                arready_s <= 1'b1;
                @(posedge ACLK);

                // arvalid_s is held, so the address transfers on this edge
                req = ar_s;
                arready_s <= 1'b0;

                for (int b = 0; b <= req.len; b++) begin
                    rvalid_s <= 1'b1;
                    r_s      <= '{id:   req.id,
                                  data: beat_data(req.addr, b),
                                  resp: `AXI_RESP_OKAY,
                                  last: (b == req.len)};
                    do begin
                        @(posedge ACLK);
                    end while (rready_s !== 1'b1);
                end
                rvalid_s <= 1'b0;
            end
        end
    end

endmodule

/* sim/axi_xbar_patterns.txt */
// group master id addr len backpressure beat0 beat1 beat2 beat3
// Records of one group run at once, one per master; group ff ends the list
00 0 3 00000040 0 0 00000040 00000000 00000000 00000000
01 0 5 00010080 0 0 10010080 00000000 00000000 00000000
02 1 a 00000124 0 0 00000124 00000000 00000000 00000000
03 1 1 0001fffc 0 0 1001fffc 00000000 00000000 00000000
04 2 f 0000fff0 0 0 0000fff0 00000000 00000000 00000000
05 2 7 00010010 0 0 10010010 00000000 00000000 00000000
// Four-beat bursts, then back-pressure
06 1 2 00000200 3 0 00000200 00000204 00000208 0000020c
07 2 9 00010300 3 1 10010300 10010304 10010308 1001030c
08 0 c 00000400 3 1 00000400 00000404 00000408 0000040c
// Two masters on different slaves
09 0 4 00000500 1 0 00000500 00000504 00000000 00000000
09 2 6 00010600 3 1 10010600 10010604 10010608 1001060c
// Three masters on one slave
0a 0 1 00000700 3 1 00000700 00000704 00000708 0000070c
0a 1 2 00000800 1 0 00000800 00000804 00000000 00000000
0a 2 3 00000900 3 0 00000900 00000904 00000908 0000090c
0b 0 e 0001a000 0 1 1001a000 00000000 00000000 00000000
0b 1 d 0001b000 3 1 1001b000 1001b004 1001b008 1001b00c
0b 2 b 0001c000 1 1 1001c000 1001c004 00000000 00000000
ff 0 0 00000000 0 0 00000000 00000000 00000000 00000000

/* sim/axi_xbar_tb.sv */
`timescale 1ns/1ps
`include "axi_xbar_macros.svh"

module axi_xbar_tb;

    localparam int PAT_WORDS = 256;
    localparam int REC_WORDS = 10;

    logic                    ACLK;
    logic                    ARESET;
    axi_xbar_pkg::ar_req_t   ar_m      [`AXI_MASTER_NUM];
    logic                    arvalid_m [`AXI_MASTER_NUM];
    logic                    arready_m [`AXI_MASTER_NUM];
    axi_xbar_pkg::r_resp_t   r_m       [`AXI_MASTER_NUM];
    logic                    rvalid_m  [`AXI_MASTER_NUM];
    logic                    rready_m  [`AXI_MASTER_NUM];
    axi_xbar_pkg::ar_req_s_t ar_s      [`AXI_SLAVE_NUM];
    logic                    arvalid_s [`AXI_SLAVE_NUM];
    logic                    arready_s [`AXI_SLAVE_NUM];
    axi_xbar_pkg::r_resp_s_t r_s       [`AXI_SLAVE_NUM];
    logic                    rvalid_s  [`AXI_SLAVE_NUM];
    logic                    rready_s  [`AXI_SLAVE_NUM];

    logic [31:0] patterns [PAT_WORDS];
    int          num_records;
    int          num_groups;
    int          watchdog_cycles;

    axi_xbar dut (.*);

    for (genvar s = 0; s < `AXI_SLAVE_NUM; s++) begin : g_slave
        axi_slave_model #(.SLAVE_IDX(s)) u_slave (
            .ACLK      (ACLK),
            .ARESET    (ARESET),
            .ar_s      (ar_s[s]),
            .arvalid_s (arvalid_s[s]),
            .arready_s (arready_s[s]),
            .r_s       (r_s[s]),
            .rvalid_s  (rvalid_s[s]),
            .rready_s  (rready_s[s])
        );
    end

    initial ACLK = 1'b0;
    always #4 ACLK = ~ACLK;

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_r_resp(input int m, input axi_xbar_pkg::r_resp_t exp,
                                input axi_xbar_pkg::r_resp_t act);
        if (act !== exp) begin
            stop_on_error($sformatf({"mismatch at %0t: r_m[%0d] expected id=%h data=%h ",
                "resp=%h last=%b, got id=%h data=%h resp=%h last=%b"}, $time, m, exp.id,
                exp.data, exp.resp, exp.last, act.id, act.data, act.resp, act.last));
        end
    endtask

    task automatic check_ar_req(input int s, input axi_xbar_pkg::ar_req_s_t exp,
                                input axi_xbar_pkg::ar_req_s_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: ar_s[%0d] expected %h, got %h",
                                    $time, s, exp, act));
        end
    endtask

    task automatic check_slot_idle(input string name, input int idx, input logic act);
        if (act !== 1'b0) begin
            stop_on_error($sformatf("mismatch at %0t: %s[%0d] expected 0, got %b",
                                    $time, name, idx, act));
        end
    endtask

    task automatic check_idle_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge ACLK);
            for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
                check_slot_idle("arvalid_s", s, arvalid_s[s]);
                check_slot_idle("rready_s", s, rready_s[s]);
            end
            for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
                check_slot_idle("arready_m", m, arready_m[m]);
                check_slot_idle("rvalid_m", m, rvalid_m[m]);
            end
        end
    endtask

    // --------------------------------------------------
    // Master driver
    // --------------------------------------------------
    task automatic run_read(input int m, input int rec);
        axi_xbar_pkg::r_resp_t   expected;
        axi_xbar_pkg::ar_req_s_t ar_exp;
        int                      base;
        int                      beat;
        int                      tgt;
        logic [3:0]              len;
        logic                    bp;
        logic                    waiting;

        base    = rec * REC_WORDS;
        len     = patterns[base+4][3:0];
        bp      = patterns[base+5][0];
        beat    = 0;
        waiting = 1'b0;
        tgt     = (patterns[base+3] >= `AXI_S1_BASE) ? 1 : 0;
        ar_exp  = '{id: `AXI_IDS_BITS'(patterns[base+2][3:0]), addr: patterns[base+3],
                    len: len, size: `AXI_SIZE_WORD, burst: `AXI_BURST_INC};

        @(posedge ACLK);
        ar_m[m]      <= '{id: patterns[base+2][3:0], addr: patterns[base+3], len: len,
                          size: `AXI_SIZE_WORD, burst: `AXI_BURST_INC};
        arvalid_m[m] <= 1'b1;
        do begin
            @(posedge ACLK);
        end while (arready_m[m] !== 1'b1);

        // Address transfers on this edge
        check_ar_req(tgt, ar_exp, ar_s[tgt]);
        arvalid_m[m] <= 1'b0;
        rready_m[m]  <= bp ? 1'($urandom_range(1, 0)) : 1'b1;

        // One beat per accepted transfer with the payload held while stalled
        while (beat <= len) begin
            @(posedge ACLK);
            if (rvalid_m[m] === 1'b1) begin
                expected = '{id: patterns[base+2][3:0], data: patterns[base+6+beat],
                             resp: `AXI_RESP_OKAY, last: (beat == len)};
                check_r_resp(m, expected, r_m[m]);
                waiting = (rready_m[m] !== 1'b1);
                if (!waiting) begin
                    beat++;
                end
            end else if (waiting) begin
                stop_on_error($sformatf("rvalid_m[%0d] dropped at %0t before beat %0d was taken",
                                        m, $time, beat));
            end
            if (bp) begin
                rready_m[m] <= 1'($urandom_range(1, 0));
            end
        end
        rready_m[m] <= 1'b0;
    endtask

    task automatic run_group_master(input int m, input int g);
        for (int r = 0; r < num_records; r++) begin
            if (patterns[r*REC_WORDS] == g && patterns[r*REC_WORDS+1] == m) begin
                run_read(m, r);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h583d_623c));
        ARESET = 1'b1;
        for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
            ar_m[m]      = '{id: '0, addr: '0, len: `AXI_LEN_ONE,
                             size: `AXI_SIZE_WORD, burst: `AXI_BURST_INC};
            arvalid_m[m] = 1'b0;
            rready_m[m]  = 1'b0;
        end
        num_records     = 0;
        num_groups      = 0;
        watchdog_cycles = 0;

        $readmemh("sim/axi_xbar_patterns.txt", patterns);
        for (int r = 0; r < PAT_WORDS / REC_WORDS; r++) begin
            if ($isunknown(patterns[r*REC_WORDS]) || patterns[r*REC_WORDS] == 32'hff) begin
                break;
            end
            if (patterns[r*REC_WORDS] >= num_groups) begin
                num_groups = patterns[r*REC_WORDS] + 1;
            end
            num_records++;
        end
        if (num_records == 0) begin
            stop_on_error("pattern file holds no read records");
        end
        watchdog_cycles = num_records * 64 + 100;

        repeat (5) @(posedge ACLK);
        ARESET <= 1'b0;
        check_idle_cycles(4);

        // Masters of one group run side by side
        for (int g = 0; g < num_groups; g++) begin
            fork
                run_group_master(0, g);
                run_group_master(1, g);
                run_group_master(2, g);
            join
            check_idle_cycles(2);
        end

        $display("All tests passed!");
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge ACLK);
        stop_on_error($sformatf("timeout: run did not finish within %0d cycles",
                                watchdog_cycles));
    end

endmodule

/* src/axi_addr_decoder.sv */
`timescale 1ns/1ps
`include "axi_xbar_macros.svh"

module axi_addr_decoder (
    input  axi_xbar_pkg::ar_req_t      ar_m         [`AXI_MASTER_NUM],
    input  logic                       arvalid_m    [`AXI_MASTER_NUM],
    output logic [`AXI_SLAVE_BITS-1:0] target_slave [`AXI_MASTER_NUM],
    output logic                       hit          [`AXI_MASTER_NUM]
);

    // --------------------------------------------------
    // Address map lookup per master
    // --------------------------------------------------
    always_comb begin
        for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
            target_slave[m] = '0;
            hit[m]          = 1'b0;

            if (ar_m[m].addr >= `AXI_S0_BASE && ar_m[m].addr <= `AXI_S0_LAST) begin
                target_slave[m] = `AXI_SLAVE_BITS'(0);
                hit[m]          = 1'b1;
            end else if (ar_m[m].addr >= `AXI_S1_BASE &&
                         ar_m[m].addr <= `AXI_S1_LAST) begin
                target_slave[m] = `AXI_SLAVE_BITS'(1);
                hit[m]          = 1'b1;
            end
        end
    end

    // Unmapped requests never get a slot, so the master would hang
    for (genvar m = 0; m < `AXI_MASTER_NUM; m++) begin : g_map_chk
        always_comb begin
            assert final (arvalid_m[m] !== 1'b1 || hit[m])
                else $error("%m: master %0d requests unmapped address %h",
                            m, ar_m[m].addr);
        end
    end

endmodule

/* src/axi_read_crossbar.sv */
`timescale 1ns/1ps
`include "axi_xbar_macros.svh"

module axi_read_crossbar (
    input  axi_xbar_pkg::slave_slot_t slot      [`AXI_SLAVE_NUM],
    // Master side
    input  axi_xbar_pkg::ar_req_t     ar_m      [`AXI_MASTER_NUM],
    input  logic                      arvalid_m [`AXI_MASTER_NUM],
    input  logic                      rready_m  [`AXI_MASTER_NUM],
    // Slave side
    input  logic                      arready_s [`AXI_SLAVE_NUM],
    input  axi_xbar_pkg::r_resp_s_t   r_s       [`AXI_SLAVE_NUM],
    input  logic                      rvalid_s  [`AXI_SLAVE_NUM],
    output axi_xbar_pkg::ar_req_s_t   ar_s      [`AXI_SLAVE_NUM],
    output logic                      arvalid_s [`AXI_SLAVE_NUM],
    output logic                      rready_s  [`AXI_SLAVE_NUM],
    output logic                      arready_m [`AXI_MASTER_NUM],
    output axi_xbar_pkg::r_resp_t     r_m       [`AXI_MASTER_NUM],
    output logic                      rvalid_m  [`AXI_MASTER_NUM]
);

    logic owned [`AXI_MASTER_NUM];

    // --------------------------------------------------
    // Routing
    // --------------------------------------------------
    always_comb begin
        axi_xbar_pkg::master_id_e owner;

        // Idle defaults
        for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
            arready_m[m] = 1'b0;
            r_m[m]       = '{id:   '0,
                             data: '0,
                             resp: `AXI_RESP_OKAY,
                             last: 1'b0};
            rvalid_m[m]  = 1'b0;
        end

        for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
            ar_s[s]      = '{id:    '0,
                             addr:  '0,
                             len:   `AXI_LEN_ONE,
                             size:  `AXI_SIZE_WORD,
                             burst: `AXI_BURST_INC};
            arvalid_s[s] = 1'b0;
            rready_s[s]  = 1'b0;
        end

        // Join each busy slave to its owner
        for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
            owner = slot[s].owner;
            if (slot[s].state == axi_xbar_pkg::slot_busy) begin
                ar_s[s]      = '{id:    `AXI_IDS_BITS'(ar_m[owner].id),
                                 addr:  ar_m[owner].addr,
                                 len:   ar_m[owner].len,
                                 size:  ar_m[owner].size,
                                 burst: ar_m[owner].burst};
                arvalid_s[s] = arvalid_m[owner];
                rready_s[s]  = rready_m[owner];

                // ID narrows back to the master width
                arready_m[owner] = arready_s[s];
                r_m[owner]       = '{id:   r_s[s].id[`AXI_ID_BITS-1:0],
                                     data: r_s[s].data,
                                     resp: r_s[s].resp,
                                     last: r_s[s].last};
                rvalid_m[owner]  = rvalid_s[s];
            end
        end
    end

    // --------------------------------------------------
    // Read data only reaches a slot owner
    // --------------------------------------------------
    always_comb begin
        for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
            owned[m] = 1'b0;
            for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
                if (slot[s].state == axi_xbar_pkg::slot_busy && slot[s].owner == m) begin
                    owned[m] = 1'b1;
                end
            end
        end
    end

    for (genvar m = 0; m < `AXI_MASTER_NUM; m++) begin : g_rvalid_chk
        always_comb begin
            assert final (rvalid_m[m] !== 1'b1 || owned[m])
                else $error("%m: rvalid to master %0d without a slot", m);
        end
    end

endmodule

/* src/axi_slave_arbiter.sv */
`timescale 1ns/1ps
`include "axi_xbar_macros.svh"

module axi_slave_arbiter (
    input  logic                       ACLK,
    input  logic                       ARESET,
    input  logic [`AXI_SLAVE_BITS-1:0] target_slave [`AXI_MASTER_NUM],
    input  logic                       hit          [`AXI_MASTER_NUM],
    input  logic                       arvalid_m    [`AXI_MASTER_NUM],
    input  logic                       rvalid_s     [`AXI_SLAVE_NUM],
    input  logic                       rready_s     [`AXI_SLAVE_NUM],
    input  axi_xbar_pkg::r_resp_s_t    r_s          [`AXI_SLAVE_NUM],
    output axi_xbar_pkg::slave_slot_t  slot         [`AXI_SLAVE_NUM]
);

    axi_xbar_pkg::master_id_e  ptr_q;
    axi_xbar_pkg::master_id_e  ptr_n;
    axi_xbar_pkg::slave_slot_t slot_q    [`AXI_SLAVE_NUM];
    axi_xbar_pkg::slave_slot_t slot_n    [`AXI_SLAVE_NUM];
    axi_xbar_pkg::req_slot_t   req_slot  [`AXI_SLAVE_NUM];
    logic                      req       [`AXI_MASTER_NUM][`AXI_SLAVE_NUM];
    logic                      last_xfer [`AXI_SLAVE_NUM];

    // --------------------------------------------------
    // Request matrix and winner per slave
    // --------------------------------------------------
    always_comb begin
        for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
            for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
                req[m][s] = arvalid_m[m] && hit[m] &&
                            (target_slave[m] == `AXI_SLAVE_BITS'(s));
            end
        end
    end

    always_comb begin
        for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
            req_slot[s] = '{valid: 1'b0, master: axi_xbar_pkg::cpu_fetch};

            // Highest-numbered requester by default
            for (int m = 0; m < `AXI_MASTER_NUM; m++) begin
                if (req[m][s]) begin
                    req_slot[s] = '{valid: 1'b1, master: axi_xbar_pkg::master_id_e'(m)};
                end
            end

            // Master under the pointer overrides
            if (req[ptr_q][s]) begin
                req_slot[s] = '{valid: 1'b1, master: ptr_q};
            end
        end
    end

    // Pointer rotates every cycle
    always_comb begin
        case (ptr_q)
            axi_xbar_pkg::cpu_fetch: ptr_n = axi_xbar_pkg::cpu_mem;
            axi_xbar_pkg::cpu_mem:   ptr_n = axi_xbar_pkg::dma;
            axi_xbar_pkg::dma:       ptr_n = axi_xbar_pkg::cpu_fetch;
            default:                 ptr_n = axi_xbar_pkg::cpu_fetch;
        endcase
    end

    // --------------------------------------------------
    // Slot state update
    // --------------------------------------------------
    always_comb begin
        for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
            last_xfer[s] = rvalid_s[s] && rready_s[s] && r_s[s].last;
            slot_n[s]    = slot_q[s];

            if (slot_q[s].state == axi_xbar_pkg::slot_idle) begin
                if (req_slot[s].valid) begin
                    slot_n[s] = '{state: axi_xbar_pkg::slot_busy,
                                  owner: req_slot[s].master};
                end
            end else if (last_xfer[s] && !req[slot_q[s].owner][s]) begin
                // Owner asking again keeps the slot
                slot_n[s].state = axi_xbar_pkg::slot_idle;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            ptr_q <= axi_xbar_pkg::cpu_fetch;
            for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
                slot_q[s] <= '{state: axi_xbar_pkg::slot_idle,
                               owner: axi_xbar_pkg::cpu_fetch};
            end
        end else begin
            ptr_q <= ptr_n;
            for (int s = 0; s < `AXI_SLAVE_NUM; s++) begin
                slot_q[s] <= slot_n[s];
            end
        end
    end

    assign slot = slot_q;

    // --------------------------------------------------
    // Ownership checks
    // --------------------------------------------------
    for (genvar a = 0; a < `AXI_SLAVE_NUM; a++) begin : g_own_a
        for (genvar b = a + 1; b < `AXI_SLAVE_NUM; b++) begin : g_own_b
            assert property (@(posedge ACLK) disable iff (ARESET)
                !(slot_q[a].state == axi_xbar_pkg::slot_busy &&
                  slot_q[b].state == axi_xbar_pkg::slot_busy &&
                  slot_q[a].owner == slot_q[b].owner))
                else $error("%m: master %0d owns slaves %0d and %0d",
                            slot_q[a].owner, a, b);
        end
    end

    // Slave read data in flight keeps its slot busy
    for (genvar s = 0; s < `AXI_SLAVE_NUM; s++) begin : g_hold_chk
        assert property (@(posedge ACLK) disable iff (ARESET)
            rvalid_s[s] |-> slot_q[s].state == axi_xbar_pkg::slot_busy)
            else $error("%m: slave %0d released before its last beat", s);
    end

endmodule

/* src/axi_xbar.sv */
`timescale 1ns/1ps
`include "axi_xbar_macros.svh"

module axi_xbar (
    input  logic                      ACLK,
    input  logic                      ARESET,

    // --------------------------------------------------
    // Master side
    // --------------------------------------------------
    input  axi_xbar_pkg::ar_req_t     ar_m      [`AXI_MASTER_NUM],
    input  logic                      arvalid_m [`AXI_MASTER_NUM],
    output logic                      arready_m [`AXI_MASTER_NUM],
    output axi_xbar_pkg::r_resp_t     r_m       [`AXI_MASTER_NUM],
    output logic                      rvalid_m  [`AXI_MASTER_NUM],
    input  logic                      rready_m  [`AXI_MASTER_NUM],

    // --------------------------------------------------
    // Slave side
    // --------------------------------------------------
    output axi_xbar_pkg::ar_req_s_t   ar_s      [`AXI_SLAVE_NUM],
    output logic                      arvalid_s [`AXI_SLAVE_NUM],
    input  logic                      arready_s [`AXI_SLAVE_NUM],
    input  axi_xbar_pkg::r_resp_s_t   r_s       [`AXI_SLAVE_NUM],
    input  logic                      rvalid_s  [`AXI_SLAVE_NUM],
    output logic                      rready_s  [`AXI_SLAVE_NUM]
);

    logic [`AXI_SLAVE_BITS-1:0] target_slave [`AXI_MASTER_NUM];
    logic                       hit          [`AXI_MASTER_NUM];
    axi_xbar_pkg::slave_slot_t  slot         [`AXI_SLAVE_NUM];

    // Address decode
    axi_addr_decoder u_decoder (
        .ar_m         (ar_m),
        .arvalid_m    (arvalid_m),
        .target_slave (target_slave),
        .hit          (hit)
    );

    // Ownership and slot registers
    axi_slave_arbiter u_arbiter (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .target_slave (target_slave),
        .hit          (hit),
        .arvalid_m    (arvalid_m),
        .rvalid_s     (rvalid_s),
        .rready_s     (rready_s),
        .r_s          (r_s),
        .slot         (slot)
    );

    // AR and R routing
    axi_read_crossbar u_crossbar (
        .slot         (slot),
        .ar_m         (ar_m),
        .arvalid_m    (arvalid_m),
        .rready_m     (rready_m),
        .arready_s    (arready_s),
        .r_s          (r_s),
        .rvalid_s     (rvalid_s),
        .ar_s         (ar_s),
        .arvalid_s    (arvalid_s),
        .rready_s     (rready_s),
        .arready_m    (arready_m),
        .r_m          (r_m),
        .rvalid_m     (rvalid_m)
    );

endmodule

/* src/axi_xbar_macros.svh */
`ifndef AXI_XBAR_MACROS_SVH
`define AXI_XBAR_MACROS_SVH

// Topology
`define AXI_MASTER_NUM   3
`define AXI_SLAVE_NUM    2
`define AXI_SLAVE_BITS   1

// Field widths
`define AXI_ID_BITS      4
`define AXI_IDS_BITS     8
`define AXI_ADDR_BITS    32
`define AXI_DATA_BITS    32
`define AXI_LEN_BITS     4
`define AXI_SIZE_BITS    3
`define AXI_BURST_BITS   2
`define AXI_RESP_BITS    2

// AXI encodings
`define AXI_RESP_OKAY    2'b00
`define AXI_BURST_INC    2'b01
`define AXI_SIZE_WORD    3'b010
`define AXI_LEN_ONE      4'h0

// Address map with 64 KB per slave
`define AXI_S0_BASE      32'h0000_0000
`define AXI_S0_LAST      32'h0000_FFFF
`define AXI_S1_BASE      32'h0001_0000
`define AXI_S1_LAST      32'h0001_FFFF

`endif

/* src/axi_xbar_pkg.sv */
`include "axi_xbar_macros.svh"

package axi_xbar_pkg;

    // Master identities in priority rotation order
    typedef enum logic [1:0] {
        cpu_fetch = 2'd0,
        cpu_mem   = 2'd1,
        dma       = 2'd2
    } master_id_e;

    typedef enum logic {
        slot_idle = 1'b0,
        slot_busy = 1'b1
    } slot_state_e;

    // --------------------------------------------------
    // AR and R payloads
    // --------------------------------------------------
    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]    id;
        logic [`AXI_ADDR_BITS-1:0]  addr;
        logic [`AXI_LEN_BITS-1:0]   len;
        logic [`AXI_SIZE_BITS-1:0]  size;
        logic [`AXI_BURST_BITS-1:0] burst;
    } ar_req_t;

    // Slave side carries the wider ID
    typedef struct packed {
        logic [`AXI_IDS_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0]  addr;
        logic [`AXI_LEN_BITS-1:0]   len;
        logic [`AXI_SIZE_BITS-1:0]  size;
        logic [`AXI_BURST_BITS-1:0] burst;
    } ar_req_s_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_DATA_BITS-1:0] data;
        logic [`AXI_RESP_BITS-1:0] resp;
        logic                      last;
    } r_resp_t;

    typedef struct packed {
        logic [`AXI_IDS_BITS-1:0]  id;
        logic [`AXI_DATA_BITS-1:0] data;
        logic [`AXI_RESP_BITS-1:0] resp;
        logic                      last;
    } r_resp_s_t;

    // --------------------------------------------------
    // Arbitration state
    // --------------------------------------------------
    typedef struct packed {
        slot_state_e state;
        master_id_e  owner;
    } slave_slot_t;

    typedef struct packed {
        logic       valid;
        master_id_e master;
    } req_slot_t;

endpackage
